/* color_out.sv */
/* 16 entry palette lookup and output stage, 2 cycles from pix_i to video_o
   rgb is forced to black whenever de is low */
`default_nettype none
`timescale 1ns/10ps

module color_out import vid_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire pix_t       pix_i,
    input  wire pal_wr_t    pal_wr_i,
    output video_out_t      video_o
);

rgb_t           palette [16];
rgb_t           rgb_1;              // looked up colour, stage one
logic           de_1;
logic           hsync_1;
logic           vsync_1;

// palette write port and lookup
always_ff @(posedge clk) begin
    if (pal_wr_i.en) begin
        palette[pal_wr_i.idx] <= pal_wr_i.rgb;
    end
    rgb_1 <= palette[pix_i.idx];
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        de_1        <= 1'b0;
        hsync_1     <= 1'b0;
        vsync_1     <= 1'b0;
        video_o     <= '0;
    end else begin
        // controls follow the lookup
        de_1        <= pix_i.de;
        hsync_1     <= pix_i.hsync;
        vsync_1     <= pix_i.vsync;

        video_o.rgb     <= de_1 ? rgb_1 : '0;   // black outside the visible area
        video_o.de      <= de_1;
        video_o.hsync   <= hsync_1;
        video_o.vsync   <= vsync_1;
    end
end

endmodule

`default_nettype wire

/* reg_interface.sv */
/* cpu register bus decode, vram access port, palette writes and interrupts
   even byte write loads the holding byte, odd byte write completes the word
   XM_ADDR and XM_DATA accesses are ignored while ST_BUSY is set */
`default_nettype none
`timescale 1ns/10ps

module reg_interface import vid_pkg::*; #(
    parameter int VRAM_AW = 10
) (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire bus_req_t   bus_i,
    output logic [7:0]      bus_data_o,
    output logic            bus_intr_o,
    output vram_req_t       vram_req_o,
    input  wire logic       vram_ack_i,
    input  wire vram_word_u vram_data_i,
    output pal_wr_t         pal_wr_o,
    input  wire logic       h_blank_i,
    input  wire logic       v_blank_i,
    input  wire intr_t      intr_trigger_i
);

localparam addr_t ADDR_MASK = addr_t'((32'd1 << VRAM_AW) - 1);   // wrap inside vram

localparam logic [1:0] S_IDLE   = 2'd0;
localparam logic [1:0] S_WR     = 2'd1;     // word write pending
localparam logic [1:0] S_RD     = 2'd2;     // read-ahead pending

logic [1:0]     state;
logic [7:0]     hold_byte;          // even byte waiting for its odd half
addr_t          xm_addr;
word_t          rd_data;            // last read-ahead word
color_t         pal_idx;
intr_t          intr_mask;
intr_t          intr_status;        // pending interrupts
intr_t          intr_clear;
logic           wr_even;
logic           wr_odd;
logic           busy;
word_t          wr_word;
word_t          rd_word;
addr_t          addr_inc;

assign wr_even  = bus_i.cs && !bus_i.rd_nwr && !bus_i.bytesel;
assign wr_odd   = bus_i.cs && !bus_i.rd_nwr && bus_i.bytesel;
assign wr_word  = {hold_byte, bus_i.data};
assign busy     = (state != S_IDLE);
assign addr_inc = (xm_addr + 1'b1) & ADDR_MASK;

// odd byte write of INT_CTRL acks pending bits
assign intr_clear = (wr_odd && bus_i.reg_num == REG_INT_CTRL) ? bus_i.data[1:0] : '0;

// register read mux
always_comb begin
    rd_word = '0;
    case (bus_i.reg_num)
        REG_XM_ADDR:    rd_word = xm_addr;
        REG_XM_DATA:    rd_word = rd_data;
        REG_INT_CTRL:   rd_word = {6'b0, intr_mask, 6'b0, intr_status};  // mask even, pending odd
        REG_PAL_ADDR:   rd_word = word_t'(pal_idx);
        REG_STATUS: begin
            rd_word[ST_BUSY]    = busy;
            rd_word[ST_HBLANK]  = h_blank_i;
            rd_word[ST_VBLANK]  = v_blank_i;
        end
        default: ;
    endcase
end

// holding byte and read data
always_ff @(posedge clk) begin
    if (wr_even) begin
        hold_byte <= bus_i.data;
    end
    if (bus_i.cs && bus_i.rd_nwr) begin
        bus_data_o <= bus_i.bytesel ? rd_word[7:0] : rd_word[15:8];   // holds until next read
    end
    if (state == S_RD && vram_ack_i) begin
        rd_data <= vram_data_i.word;
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        state       <= S_IDLE;
        vram_req_o  <= '0;
        xm_addr     <= '0;
        pal_idx     <= '0;
        pal_wr_o    <= '0;
        intr_mask   <= '0;
        intr_status <= '0;
        bus_intr_o  <= 1'b0;
    end else begin
        pal_wr_o.en <= 1'b0;                // strobe

        // pulse only for new, unmasked triggers
        bus_intr_o  <= |(intr_trigger_i & intr_mask & ~intr_status);
        intr_status <= (intr_status | intr_trigger_i) & ~intr_clear;

        if (wr_even && bus_i.reg_num == REG_INT_CTRL) begin
            intr_mask <= bus_i.data[1:0];
        end

        if (wr_odd) begin
            case (bus_i.reg_num)
                REG_XM_ADDR: if (!busy) begin
                    xm_addr         <= wr_word & ADDR_MASK;
                    vram_req_o.sel  <= 1'b1;        // read-ahead at new address
                    vram_req_o.wr   <= 1'b0;
                    vram_req_o.addr <= wr_word & ADDR_MASK;
                    state           <= S_RD;
                end
                REG_XM_DATA: if (!busy) begin
                    vram_req_o.sel  <= 1'b1;
                    vram_req_o.wr   <= 1'b1;
                    vram_req_o.addr <= xm_addr;
                    vram_req_o.data <= wr_word;
                    state           <= S_WR;
                end
                REG_PAL_ADDR: pal_idx <= wr_word[3:0];
                REG_PAL_DATA: begin
                    pal_wr_o.en     <= 1'b1;
                    pal_wr_o.idx    <= pal_idx;
                    pal_wr_o.rgb    <= wr_word[11:0];
                    pal_idx         <= pal_idx + 1'b1;  // auto increment
                end
                default: ;
            endcase
        end

        case (state)
            S_WR: if (vram_ack_i) begin
                xm_addr         <= addr_inc;
                vram_req_o.wr   <= 1'b0;            // sel stays up, now a read-ahead
                vram_req_o.addr <= addr_inc;
                state           <= S_RD;
            end
            S_RD: if (vram_ack_i) begin
                vram_req_o.sel  <= 1'b0;
                state           <= S_IDLE;
            end
            default: ;
        endcase
    end
end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and checks the log for the pass line
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -j 0 --top-module tb_vid_main \
    -f vid_main.f -Mdir "$BUILD_DIR" -o vsim_tb_vid_main
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/vsim_tb_vid_main" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
    exit 0
fi
exit 1

/* tb_vid_main.sv */
/* testbench for vid_main, random vram and palette contents from a fixed seed
   a monitor samples video_o on every rising edge and checks it against the model
   timing parameters are the defaults of vid_main, held here as localparams */
`default_nettype none
`timescale 1ns/10ps

module tb_vid_main import vid_pkg::*; ();

localparam int H_VIS           = 32;
localparam int H_TOTAL         = 40;
localparam int H_SYNC_START    = 34;
localparam int H_SYNC_END      = 36;
localparam int V_VIS           = 16;
localparam int V_TOTAL         = 20;
localparam int V_SYNC_START    = 17;
localparam int V_SYNC_END      = 18;
localparam int VRAM_AW         = 10;
localparam int FRAME           = H_TOTAL * V_TOTAL;    // cycles per frame
localparam int WORDS           = V_VIS * H_VIS / 4;    // bitmap words
localparam int WATCHDOG_CYCLES = 2 * 20 * FRAME;       // ~20 frames of tests, doubled
localparam logic [31:0] SEED   = 32'h532c01fd;
localparam intr_t VBL          = intr_t'(1 << VBLANK_INTR);
localparam intr_t LINE         = intr_t'(1 << LINE_INTR);

typedef logic [VRAM_AW-1:0] vaddr_t;

logic           clk;
logic           reset_i;
bus_req_t       bus;
logic [7:0]     bus_data;
logic           bus_intr;
video_out_t     video;

word_t          model_vram [2**VRAM_AW];
rgb_t           model_pal [16];
intr_t          model_mask;
intr_t          model_pending;

int             pass_count = 0;
int             err_count = 0;
int             cyc = 0;                // output sample index
bit             mon_on = 1'b0;
int             scan_state = 0;         // 0 off, 1 armed, 2 capturing, 3 done
int             last_hs = 0;
int             last_vs = 0;
bit             hs_seen = 1'b0;
bit             vs_seen = 1'b0;
int             vs_count = 0;
bit             prev_hs = 1'b0;
bit             prev_vs = 1'b0;
bit             prev_de = 1'b0;
int             de_cnt = 0;             // de pixels in the current line
int             line_cnt = 0;           // de lines since last vsync
int             intr_pulses = 0;
int             last_intr_cyc = 0;

vid_main #(
    .H_VIS(H_VIS),
    .H_TOTAL(H_TOTAL),
    .H_SYNC_START(H_SYNC_START),
    .H_SYNC_END(H_SYNC_END),
    .V_VIS(V_VIS),
    .V_TOTAL(V_TOTAL),
    .V_SYNC_START(V_SYNC_START),
    .V_SYNC_END(V_SYNC_END),
    .VRAM_AW(VRAM_AW)
) dut0 (
    .clk(clk),
    .reset_i(reset_i),
    .bus_i(bus),
    .bus_data_o(bus_data),
    .bus_intr_o(bus_intr),
    .video_o(video)
);

bind vid_main vid_main_assertions assertions0 (
    .clk(clk),
    .reset_i(reset_i),
    .vgen_req(vgen_req),
    .vgen_ack(vgen_ack),
    .regs_req(regs_req),
    .regs_ack(regs_ack),
    .video_o(video_o),
    .bus_intr_o(bus_intr_o)
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;     // 100 ns period
end

initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: tests still running after %0d clock cycles", WATCHDOG_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
end

task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got === exp) begin
        pass_count++;
    end else begin
        err_count++;
        $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_rgb(input rgb_t got, input rgb_t exp, input string what);
    if (got === exp) begin
        pass_count++;
    end else begin
        err_count++;
        $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_intr(input intr_t got, input intr_t exp, input string what);
    if (got === exp) begin
        pass_count++;
    end else begin
        err_count++;
        $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic report_test(input int num, input string name, input int errs_before);
    $display("test %0d %s: %s, %0d errors", num, name,
             (err_count == errs_before) ? "ok" : "failed", err_count - errs_before);
endtask

// one bus access, called on a falling edge and returns on the next one
task automatic bus_cycle(input logic rd, input logic [3:0] reg_num, input logic odd,
                         input logic [7:0] wdata, output logic [7:0] rdata);
    bus.cs      = 1'b1;
    bus.rd_nwr  = rd;
    bus.reg_num = reg_num;
    bus.bytesel = odd;
    bus.data    = wdata;
    @(negedge clk);
    bus   = '0;
    rdata = bus_data;           // valid one cycle after cs
endtask

task automatic write_reg(input logic [3:0] reg_num, input word_t w);
    logic [7:0] unused;
    bus_cycle(1'b0, reg_num, 1'b0, w[15:8], unused);   // even byte into holding reg
    bus_cycle(1'b0, reg_num, 1'b1, w[7:0], unused);    // odd byte completes
endtask

task automatic read_reg(input logic [3:0] reg_num, output word_t w);
    bus_cycle(1'b1, reg_num, 1'b0, 8'h00, w[15:8]);
    bus_cycle(1'b1, reg_num, 1'b1, 8'h00, w[7:0]);
endtask

// STATUS read, vblank flag checked against the raster position seen at video_o
task automatic read_status(output logic [7:0] st);
    int pos = 0;
    int h = 0;
    int v = 0;
    if (vs_seen) begin
        pos = (cyc + 3 - last_vs) % FRAME;      // output slot of the counters seen now
        h   = pos % H_TOTAL;
        v   = (V_SYNC_START + pos / H_TOTAL) % V_TOTAL;
    end
    bus_cycle(1'b1, REG_STATUS, 1'b1, 8'h00, st);
    if (vs_seen && h >= 4 && h < H_TOTAL - 4) begin  // keep clear of line edges
        check_word(word_t'(st[ST_VBLANK]), word_t'(v >= V_VIS), "STATUS vblank flag");
    end
endtask

task automatic wait_idle();
    logic [7:0] st;
    int tries;
    tries = 0;
    do begin
        read_status(st);
        tries++;
    end while (st[ST_BUSY] && tries < 20);
    if (st[ST_BUSY]) begin
        err_count++;
        $display("VRAM port still busy after %0d status reads at %0t", tries, $time);
    end
endtask

// k-th visible pixel of line y, leftmost pixel in the high nibble
function automatic rgb_t expected_pixel(input int y, input int k);
    word_t  w;
    color_t idx;
    w   = model_vram[vaddr_t'(y * (H_VIS / 4) + k / 4)];
    idx = color_t'(w >> (4 * (3 - k % 4)));
    return model_pal[idx];
endfunction

// output monitor, samples the values set before this edge
always @(posedge clk) begin
    cyc++;
    if (mon_on) begin
        if (!video.de) begin
            check_rgb(video.rgb, '0, "rgb outside de");
        end
        if (bus_intr) begin
            intr_pulses++;
            last_intr_cyc = cyc;
        end
        if (video.hsync && !prev_hs) begin
            if (hs_seen) check_word(word_t'(cyc - last_hs), word_t'(H_TOTAL), "hsync period");
            hs_seen = 1'b1;
            last_hs = cyc;
        end
        if (!video.hsync && prev_hs && hs_seen) begin
            check_word(word_t'(cyc - last_hs), word_t'(H_SYNC_END - H_SYNC_START),
                       "hsync width");
        end
        if (video.vsync && !prev_vs) begin
            if (vs_seen) begin
                check_word(word_t'(cyc - last_vs), word_t'(FRAME), "vsync period");
                check_word(word_t'(line_cnt), word_t'(V_VIS), "de lines per frame");
            end
            vs_seen  = 1'b1;
            last_vs  = cyc;
            vs_count++;
            line_cnt = 0;
            if (scan_state == 2) scan_state = 3;
            else if (scan_state == 1) scan_state = 2;   // frame starts after this vsync
        end
        if (!video.vsync && prev_vs && vs_seen) begin
            check_word(word_t'(cyc - last_vs), word_t'((V_SYNC_END - V_SYNC_START) * H_TOTAL),
                       "vsync width");
        end
        if (video.de) begin
            if (scan_state == 2) begin
                check_rgb(video.rgb, expected_pixel(line_cnt, de_cnt), "scanned pixel");
            end
            de_cnt++;
        end else if (prev_de) begin
            check_word(word_t'(de_cnt), word_t'(H_VIS), "de pixels per line");
            line_cnt++;
            de_cnt = 0;
        end
        prev_hs = video.hsync;
        prev_vs = video.vsync;
        prev_de = video.de;
    end
end

initial begin
    word_t      w;
    rgb_t       c;
    logic [7:0] b;
    int         n;
    int         prev_cyc;
    int         test_err;

    void'($urandom(SEED));
    bus           = '0;
    reset_i       = 1'b1;
    model_mask    = '0;
    model_pending = '0;
    prev_cyc      = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;
    mon_on  = 1'b1;

    // 1: bitmap written with auto-increment, then read back word by word
    test_err = err_count;
    write_reg(REG_XM_ADDR, 16'h0000);
    wait_idle();
    for (int i = 0; i < WORDS; i++) begin
        w = word_t'($urandom);
        model_vram[vaddr_t'(i)] = w;
        write_reg(REG_XM_DATA, w);
        wait_idle();
    end
    read_reg(REG_XM_ADDR, w);
    check_word(w, word_t'(WORDS), "XM_ADDR after writes");
    for (int i = 0; i < WORDS; i++) begin
        write_reg(REG_XM_ADDR, word_t'(i));
        wait_idle();
        read_reg(REG_XM_DATA, w);
        check_word(w, model_vram[vaddr_t'(i)], "XM_DATA read-back");
    end
    report_test(1, "vram write and read-back", test_err);

    // 2: all 16 palette entries, index wraps back to 0
    test_err = err_count;
    write_reg(REG_PAL_ADDR, 16'h0000);
    for (int i = 0; i < 16; i++) begin
        c = rgb_t'($urandom);
        model_pal[color_t'(i)] = c;
        write_reg(REG_PAL_DATA, word_t'(c));
    end
    read_reg(REG_PAL_ADDR, w);
    check_word(w, 16'h0000, "PAL_ADDR after 16 writes");
    report_test(2, "palette programming", test_err);

    // 3: one full frame compared pixel by pixel
    test_err   = err_count;
    scan_state = 1;
    while (scan_state != 3) @(negedge clk);
    report_test(3, "pixel scan-out", test_err);

    // 4: sync periods, widths and black outside de over two more frames
    test_err = err_count;
    n        = vs_count;
    while (vs_count < n + 2) @(negedge clk);
    report_test(4, "sync and blanking shape", test_err);

    // 5: vblank interrupt, masked in, cleared every frame
    test_err      = err_count;
    model_mask    = VBL;
    write_reg(REG_INT_CTRL, {6'b0, model_mask, 8'h03});
    model_pending = '0;
    for (int f = 0; f < 3; f++) begin
        n = intr_pulses;
        while (intr_pulses == n) @(negedge clk);
        if (f > 0) begin
            check_word(word_t'(last_intr_cyc - prev_cyc), word_t'(FRAME), "interrupt spacing");
        end
        prev_cyc      = last_intr_cyc;
        model_pending = model_pending | VBL;
        bus_cycle(1'b1, REG_INT_CTRL, 1'b1, 8'h00, b);
        check_intr(intr_t'(b) & VBL, model_pending & VBL, "pending after vblank");
        write_reg(REG_INT_CTRL, {6'b0, model_mask, 6'b0, VBL});
        model_pending = model_pending & ~VBL;
        bus_cycle(1'b1, REG_INT_CTRL, 1'b1, 8'h00, b);
        check_intr(intr_t'(b) & VBL, model_pending & VBL, "pending after clear");
    end
    // mask zero, no pulses but pending keeps collecting
    model_mask = '0;
    write_reg(REG_INT_CTRL, {6'b0, model_mask, 8'h03});
    model_pending = '0;
    n = intr_pulses;
    repeat (2 * FRAME) @(negedge clk);
    check_word(word_t'(intr_pulses - n), 16'h0000, "interrupt pulses with mask zero");
    model_pending = VBL | LINE;                 // two frames hold both triggers
    bus_cycle(1'b1, REG_INT_CTRL, 1'b1, 8'h00, b);
    check_intr(intr_t'(b), model_pending, "pending with mask zero");
    report_test(5, "interrupts", test_err);

    // 6: STATUS reads at random gaps over more than a frame
    test_err = err_count;
    repeat (120) begin
        repeat ($urandom % 20) @(negedge clk);
        read_status(b);
    end
    report_test(6, "status flags", test_err);

    $display("summary: %0d checks passed, %0d errors", pass_count, err_count);
    if (err_count == 0) begin
        $display("TESTBENCH PASSED");
    end else begin
        $display("TESTBENCH FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire

/* vid_main.f */
vid_pkg.sv
reg_interface.sv
video_gen.sv
vram_arb.sv
color_out.sv
vid_main.sv
vid_main_assertions.sv
tb_vid_main.sv

/* vid_main.sv */
/* top level of the bitmap video controller, wiring only
   timing defaults give a tiny test raster, real modes set them from above */
`default_nettype none
`timescale 1ns/10ps

module vid_main import vid_pkg::*; #(
    parameter int H_VIS         = 32,   // visible pixels, multiple of 4
    parameter int H_TOTAL       = 40,   // at least H_VIS + 4
    parameter int H_SYNC_START  = 34,
    parameter int H_SYNC_END    = 36,
    parameter int V_VIS         = 16,
    parameter int V_TOTAL       = 20,
    parameter int V_SYNC_START  = 17,
    parameter int V_SYNC_END    = 18,
    parameter int VRAM_AW       = 10    // 2^VRAM_AW words of vram
) (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire bus_req_t   bus_i,          // cpu register bus
    output logic [7:0]      bus_data_o,     // read byte, one cycle after cs
    output logic            bus_intr_o,     // one-cycle interrupt pulse
    output video_out_t      video_o
);

vram_req_t      vgen_req;           // video fetch, read only
logic           vgen_ack;
vram_req_t      regs_req;           // cpu port
logic           regs_ack;
vram_word_u     vram_data;          // shared read data
pal_wr_t        pal_wr;
pix_t           pix;                // pixel index with de and syncs
logic           h_blank;
logic           v_blank;
intr_t          intr_trigger;

reg_interface #(
    .VRAM_AW(VRAM_AW)
) reg_interface0 (
    .clk(clk),
    .reset_i(reset_i),
    .bus_i(bus_i),
    .bus_data_o(bus_data_o),
    .bus_intr_o(bus_intr_o),
    .vram_req_o(regs_req),
    .vram_ack_i(regs_ack),
    .vram_data_i(vram_data),
    .pal_wr_o(pal_wr),
    .h_blank_i(h_blank),
    .v_blank_i(v_blank),
    .intr_trigger_i(intr_trigger)
);

video_gen #(
    .H_VIS(H_VIS),
    .H_TOTAL(H_TOTAL),
    .H_SYNC_START(H_SYNC_START),
    .H_SYNC_END(H_SYNC_END),
    .V_VIS(V_VIS),
    .V_TOTAL(V_TOTAL),
    .V_SYNC_START(V_SYNC_START),
    .V_SYNC_END(V_SYNC_END)
) video_gen0 (
    .clk(clk),
    .reset_i(reset_i),
    .vram_req_o(vgen_req),
    .vram_ack_i(vgen_ack),
    .vram_data_i(vram_data),
    .pix_o(pix),
    .h_blank_o(h_blank),
    .v_blank_o(v_blank),
    .intr_trigger_o(intr_trigger)
);

vram_arb #(
    .VRAM_AW(VRAM_AW)
) vram_arb0 (
    .clk(clk),
    .vgen_req_i(vgen_req),
    .vgen_ack_o(vgen_ack),
    .regs_req_i(regs_req),
    .regs_ack_o(regs_ack),
    .vram_data_o(vram_data)
);

color_out color_out0 (
    .clk(clk),
    .reset_i(reset_i),
    .pix_i(pix),
    .pal_wr_i(pal_wr),
    .video_o(video_o)
);

endmodule

`default_nettype wire

/* vid_main_assertions.sv */
/* protocol assertions bound into vid_main, disabled while reset_i is high
   covers the vram acks, black outside de and the interrupt pulse width */
`default_nettype none
`timescale 1ns/10ps

module vid_main_assertions import vid_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire vram_req_t  vgen_req,
    input  wire logic       vgen_ack,
    input  wire vram_req_t  regs_req,
    input  wire logic       regs_ack,
    input  wire video_out_t video_o,
    input  wire logic       bus_intr_o
);

// video fetches are spaced apart, sel is already low when its ack arrives
vgen_sel_dropped_at_ack: assert property (@(posedge clk) disable iff (reset_i)
    vgen_ack |-> !vgen_req.sel) else $error("video port sel still high in its ack cycle");

// cpu sel is held through the ack cycle
regs_ack_with_sel: assert property (@(posedge clk) disable iff (reset_i)
    regs_ack |-> regs_req.sel) else $error("cpu port ack without sel");

black_outside_de: assert property (@(posedge clk) disable iff (reset_i)
    !video_o.de |-> video_o.rgb == '0) else $error("rgb not black while de is low");

intr_single_pulse: assert property (@(posedge clk) disable iff (reset_i)
    bus_intr_o |=> !bus_intr_o) else $error("bus_intr_o high for two cycles");

endmodule

`default_nettype wire

/* vid_pkg.sv */
/* shared types and register map for the bitmap video controller
   addr_t carries a full word, the VRAM only decodes its low VRAM_AW bits
   register numbers are 4 bits, STATUS flags live in the odd (low) byte */
`default_nettype none

package vid_pkg;

typedef logic [15:0] word_t;            // cpu and vram data word
typedef logic [15:0] addr_t;            // vram word address
typedef logic [3:0]  color_t;           // palette index
typedef logic [11:0] rgb_t;             // 4 bits each of r, g, b
typedef logic [1:0]  intr_t;            // one bit per interrupt source

localparam int VBLANK_INTR  = 0;        // first cycle of line V_VIS
localparam int LINE_INTR    = 1;        // start of every hblank

// cpu register numbers
localparam logic [3:0] REG_XM_ADDR  = 4'h0;
localparam logic [3:0] REG_XM_DATA  = 4'h1;
localparam logic [3:0] REG_INT_CTRL = 4'h2;
localparam logic [3:0] REG_PAL_ADDR = 4'h3;
localparam logic [3:0] REG_PAL_DATA = 4'h4;
localparam logic [3:0] REG_STATUS   = 4'h5;

// STATUS bit positions
localparam int ST_BUSY      = 0;
localparam int ST_HBLANK    = 1;
localparam int ST_VBLANK    = 2;

// vram word seen by the cpu, or as four pixels with pix[3] leftmost
typedef union packed {
    word_t          word;
    color_t [3:0]   pix;
} vram_word_u;

typedef struct packed {
    logic           cs;                 // one-cycle access strobe
    logic           rd_nwr;             // 1 read, 0 write
    logic [3:0]     reg_num;
    logic           bytesel;            // 0 = even (high) byte
    logic [7:0]     data;
} bus_req_t;

typedef struct packed {
    logic           sel;                // held until ack
    logic           wr;
    addr_t          addr;
    word_t          data;
} vram_req_t;

typedef struct packed {
    logic           en;                 // single cycle strobe
    color_t         idx;
    rgb_t           rgb;
} pal_wr_t;

typedef struct packed {
    color_t         idx;
    logic           de;
    logic           hsync;
    logic           vsync;
} pix_t;

typedef struct packed {
    rgb_t           rgb;
    logic           de;
    logic           hsync;
    logic           vsync;
} video_out_t;

endpackage

`default_nettype wire

/* video_gen.sv */
/* raster timing and bitmap fetch, 4 bits per pixel, H_VIS/4 words per line
   needs H_VIS a multiple of 4 and H_TOTAL >= H_VIS + 4, syncs active high
   outputs are registered and lag the counters by one cycle */
`default_nettype none
`timescale 1ns/10ps

module video_gen import vid_pkg::*; #(
    parameter int H_VIS         = 32,
    parameter int H_TOTAL       = 40,
    parameter int H_SYNC_START  = 34,
    parameter int H_SYNC_END    = 36,
    parameter int V_VIS         = 16,
    parameter int V_TOTAL       = 20,
    parameter int V_SYNC_START  = 17,
    parameter int V_SYNC_END    = 18
) (
    input  wire logic       clk,
    input  wire logic       reset_i,
    output vram_req_t       vram_req_o,
    input  wire logic       vram_ack_i,
    input  wire vram_word_u vram_data_i,
    output pix_t            pix_o,
    output logic            h_blank_o,
    output logic            v_blank_o,
    output intr_t           intr_trigger_o
);

localparam int HW = $clog2(H_TOTAL);
localparam int VW = $clog2(V_TOTAL);

logic [HW-1:0]  h_count;
logic [VW-1:0]  v_count;
logic           h_last;
logic           v_last;
logic           h_vis;
logic           v_vis;
logic           fetch_line;         // words 1.. during the line
logic           fetch_pre;          // word 0 during the previous hblank
logic           fetch_go;
addr_t          fetch_addr;         // runs linearly through the frame
vram_word_u     next_word;
color_t [3:0]   pix_sr;             // pix_sr[3] is the current pixel

assign h_last   = (h_count == HW'(H_TOTAL - 1));
assign v_last   = (v_count == VW'(V_TOTAL - 1));
assign h_vis    = (h_count < HW'(H_VIS));
assign v_vis    = (v_count < VW'(V_VIS));

// one request per 4 pixels, ack comes 1 cycle later, data used 2 cycles after that
assign fetch_line = v_vis && (h_count[1:0] == 2'b00) && (h_count < HW'(H_VIS - 4));
assign fetch_pre  = (h_count == HW'(H_TOTAL - 4)) && (v_last || v_count < VW'(V_VIS - 1));
assign fetch_go   = fetch_line || fetch_pre;

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count         <= '0;
        v_count         <= '0;
        fetch_addr      <= '0;
        vram_req_o      <= '0;
        pix_o           <= '0;
        h_blank_o       <= 1'b0;
        v_blank_o       <= 1'b0;
        intr_trigger_o  <= '0;
    end else begin
        h_count <= h_last ? '0 : h_count + 1'b1;
        if (h_last) begin
            v_count <= v_last ? '0 : v_count + 1'b1;
        end

        // single cycle select, read only port
        vram_req_o.sel  <= fetch_go;
        vram_req_o.wr   <= 1'b0;
        vram_req_o.addr <= fetch_addr;
        vram_req_o.data <= '0;
        if (fetch_go) begin
            fetch_addr <= fetch_addr + 1'b1;
        end else if (h_count == '0 && v_count == VW'(V_VIS)) begin
            fetch_addr <= '0;           // rewind once per frame in vblank
        end

        pix_o.idx   <= pix_sr[3];
        pix_o.de    <= h_vis && v_vis;
        pix_o.hsync <= (h_count >= HW'(H_SYNC_START)) && (h_count < HW'(H_SYNC_END));
        pix_o.vsync <= (v_count >= VW'(V_SYNC_START)) && (v_count < VW'(V_SYNC_END));
        h_blank_o   <= !h_vis;
        v_blank_o   <= !v_vis;

        intr_trigger_o[VBLANK_INTR] <= (v_count == VW'(V_VIS)) && (h_count == '0);
        intr_trigger_o[LINE_INTR]   <= (h_count == HW'(H_VIS));
    end
end

// fetched word and pixel shift register
always_ff @(posedge clk) begin
    if (vram_ack_i) begin
        next_word <= vram_data_i;
    end
    if (h_count[1:0] == 2'b11 || h_last) begin
        pix_sr <= next_word.pix;                    // load before each group of 4
    end else begin
        pix_sr <= {pix_sr[2:0], color_t'(0)};       // high nibble first
    end
end

endmodule

`default_nettype wire

/* vram_arb.sv */
/* single port vram with fixed priority, video generator first
   the video port is read only, its ack follows sel by exactly one cycle
   read data is valid in the ack cycle */
`default_nettype none
`timescale 1ns/10ps

module vram_arb import vid_pkg::*; #(
    parameter int VRAM_AW = 10
) (
    input  wire logic       clk,
    input  wire vram_req_t  vgen_req_i,     // sel for one cycle only
    output logic            vgen_ack_o,
    input  wire vram_req_t  regs_req_i,     // sel held until ack
    output logic            regs_ack_o,
    output vram_word_u      vram_data_o
);

word_t          mem [2**VRAM_AW];       // one access per cycle
logic           regs_grant;

// skip the ack cycle so a held sel is not served twice
assign regs_grant = regs_req_i.sel && !regs_ack_o && !vgen_req_i.sel;

always_ff @(posedge clk) begin
    vgen_ack_o <= vgen_req_i.sel;
    regs_ack_o <= regs_grant;
end

always_ff @(posedge clk) begin
    if (vgen_req_i.sel) begin
        vram_data_o.word <= mem[vgen_req_i.addr[VRAM_AW-1:0]];
    end else if (regs_grant) begin
        if (regs_req_i.wr) begin
            mem[regs_req_i.addr[VRAM_AW-1:0]] <= regs_req_i.data;
        end
        vram_data_o.word <= mem[regs_req_i.addr[VRAM_AW-1:0]];   // old word on a write
    end
end

endmodule

`default_nettype wire
